// ==== design/spi_rx_bus_pkg.sv ====
//########################################
// Register bus definitions for the receiver
// Address and data types of the byte bus
// Register map and version constant
//########################################

package spi_rx_bus_pkg;

    localparam int BUS_AW = 4;
    localparam int BUS_DW = 8;

    typedef logic [BUS_AW-1:0] bus_addr_t;
    typedef logic [BUS_DW-1:0] bus_data_t;

    // Write is a soft reset, read returns the version
    localparam bus_addr_t ADDR_RESET = 4'd0;

    // Bit 0 is the receiver enable
    localparam bus_addr_t ADDR_CONF = 4'd2;

    // Saturating count of dropped words
    localparam bus_addr_t ADDR_LOST = 4'd3;

    localparam bus_data_t VERSION = 8'd1;

endpackage

// ==== design/spi_rx_data_pkg.sv ====
//########################################
// Data path definitions for the receiver
// Record layout, field widths, source id
// FIFO depth and lost-word counter type
//########################################

package spi_rx_data_pkg;

    localparam int ID_BITS    = 4;
    localparam int FRAME_BITS = 12;
    localparam int WORD_BITS  = 16;

    // Pending-bit counter must reach WORD_BITS
    localparam int BIT_CNT_BITS = $clog2(WORD_BITS) + 1;

    localparam logic [ID_BITS-1:0] SOURCE_ID = 4'b0001;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // One output record, top bit first
    typedef struct packed {
        logic [ID_BITS-1:0]    source_id;
        logic [FRAME_BITS-1:0] frame;
        logic [WORD_BITS-1:0]  data;
    } spi_rx_record_t;

    typedef logic [7:0] lost_cnt_t;

endpackage

// ==== design/spi_rx_deser.sv ====
//########################################
// Serial deserializer
// Frame edge detection and bit shifting
// Word cutting, frame numbering
// Record writes and lost-word counting
//########################################

`timescale 1ns/1ps

module spi_rx_deser
    import spi_rx_data_pkg::*;
(
    input  logic           SCLK,
    input  logic           clear,
    input  logic           conf_en,
    input  logic           sdi,
    input  logic           sen,
    input  logic           fifo_full,
    output spi_rx_record_t rec,
    output logic           rec_write,
    output lost_cnt_t      lost_cnt
);

    logic                    sen_dly;
    logic                    frame_end;
    logic                    word_done;
    logic                    word_ready;
    logic                    word_take;
    logic [BIT_CNT_BITS-1:0] bit_cnt;
    logic [WORD_BITS-1:0]    shift_reg;
    logic [WORD_BITS-1:0]    word_data;
    logic [FRAME_BITS-1:0]   frame_cnt;

    // Frame ends when SEN is sampled low after being high
    assign frame_end = sen_dly && !sen;

    // The bit sampled now completes a word
    assign word_done = sen && (bit_cnt == BIT_CNT_BITS'(WORD_BITS - 1));

    // Full word, or a partial tail with bits pending
    assign word_ready = word_done || (frame_end && (bit_cnt != '0));
    assign word_take  = word_ready && conf_en;

    // Tail bits already sit right-aligned in the shift register
    assign word_data = word_done ? {shift_reg[WORD_BITS-2:0], sdi} : shift_reg;

    always_ff @(posedge SCLK) begin
        if (clear) begin
            sen_dly   <= 1'b0;
            bit_cnt   <= '0;
            shift_reg <= '0;
        end else begin
            sen_dly <= sen;
            if (word_done || frame_end) begin
                bit_cnt   <= '0;
                shift_reg <= '0;
            end else if (sen) begin
                bit_cnt   <= bit_cnt + 1'b1;
                shift_reg <= {shift_reg[WORD_BITS-2:0], sdi};
            end
        end
    end

    // Frame number holds while disabled, wraps at 12 bits
    always_ff @(posedge SCLK) begin
        if (clear) begin
            frame_cnt <= '0;
        end else if (frame_end && conf_en) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    always_ff @(posedge SCLK) begin
        if (clear) begin
            rec_write <= 1'b0;
            lost_cnt  <= '0;
        end else begin
            rec_write <= word_take && !fifo_full;
            if (word_take && fifo_full && (lost_cnt != '1)) begin
                lost_cnt <= lost_cnt + 1'b1;
            end
        end
    end

    // Record carries the number of the frame it belongs to
    always_ff @(posedge SCLK) begin
        if (word_ready) begin
            rec.source_id <= SOURCE_ID;
            rec.frame     <= frame_cnt;
            rec.data      <= word_data;
        end
    end

    a_no_write_when_full: assert property (
        @(posedge SCLK) disable iff (clear) !(rec_write && fifo_full)
    ) else $error("record write issued while the FIFO is full");

    a_bit_cnt_range: assert property (
        @(posedge SCLK) disable iff (clear) bit_cnt <= BIT_CNT_BITS'(WORD_BITS)
    ) else $error("pending bit count out of range");

endmodule

// ==== design/spi_rx_fifo.sv ====
//########################################
// Show-ahead single-clock record FIFO
// Circular buffer with occupancy count
// Full and empty flags
//########################################

`timescale 1ns/1ps

module spi_rx_fifo
    import spi_rx_data_pkg::*;
(
    input  logic           SCLK,
    input  logic           clear,
    input  logic           write,
    input  spi_rx_record_t wdata,
    input  logic           read,
    output spi_rx_record_t rdata,
    output logic           full,
    output logic           empty
);

    spi_rx_record_t       mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0]   wr_ptr;
    logic [FIFO_AW-1:0]   rd_ptr;
    logic [FIFO_AW:0]     count;
    logic                 do_write;
    logic                 do_read;

    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Stored records are never overwritten, empty reads are ignored
    assign do_write = write && !full;
    assign do_read  = read && !empty;

    // Head record is visible without a read
    assign rdata = mem[rd_ptr];

    always_ff @(posedge SCLK) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge SCLK) begin
        if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    a_write_when_full: assert property (
        @(posedge SCLK) disable iff (clear) !(write && full)
    ) else $error("write to a full FIFO");

    a_read_when_empty: assert property (
        @(posedge SCLK) disable iff (clear) !(read && empty)
    ) else $error("read from an empty FIFO");

endmodule

// ==== design/spi_rx_regs.sv ====
//########################################
// Control register bank
// Enable bit, soft reset decode
// Registered read-back of the register map
//########################################

`timescale 1ns/1ps

module spi_rx_regs
    import spi_rx_bus_pkg::*;
    import spi_rx_data_pkg::*;
(
    input  logic      SCLK,
    input  logic      RST,
    input  bus_addr_t bus_add,
    input  bus_data_t bus_data_in,
    input  logic      bus_wr,
    output bus_data_t bus_data_out,
    input  lost_cnt_t lost_cnt,
    output logic      conf_en,
    output logic      clear
);

    logic soft_rst;

    // Soft reset acts on the same edge as the bus write
    assign soft_rst = bus_wr && (bus_add == ADDR_RESET);
    assign clear    = RST || soft_rst;

    always_ff @(posedge SCLK) begin
        if (clear) begin
            conf_en <= 1'b0;
        end else if (bus_wr && (bus_add == ADDR_CONF)) begin
            conf_en <= bus_data_in[0];
        end
    end

    // Read data is valid one cycle after the address
    always_ff @(posedge SCLK) begin
        if (RST) begin
            bus_data_out <= '0;
        end else begin
            case (bus_add)
                ADDR_RESET: begin
                    bus_data_out <= VERSION;
                end
                ADDR_CONF: begin
                    bus_data_out <= bus_data_t'(conf_en);
                end
                ADDR_LOST: begin
                    bus_data_out <= bus_data_t'(lost_cnt);
                end
                default: begin
                    bus_data_out <= '0;
                end
            endcase
        end
    end

    // A soft reset write reaches the deserializer and zeroes the lost count
    a_soft_rst_clears: assert property (
        @(posedge SCLK) (bus_wr && (bus_add == ADDR_RESET)) |=> (lost_cnt == '0)
    ) else $error("soft reset write did not clear the lost count");

endmodule

// ==== design/spi_rx_top.sv ====
//########################################
// Serial receiver top level
// Register bank, deserializer and FIFO
//########################################

`timescale 1ns/1ps

module spi_rx_top
    import spi_rx_bus_pkg::*;
    import spi_rx_data_pkg::*;
(
    input  logic           SCLK,
    input  logic           RST,
    input  logic           sdi,
    input  logic           sen,
    input  logic           fifo_read,
    output logic           fifo_empty,
    output spi_rx_record_t fifo_data,
    input  bus_addr_t      bus_add,
    input  bus_data_t      bus_data_in,
    input  logic           bus_wr,
    output bus_data_t      bus_data_out
);

    logic           conf_en;
    logic           clear;
    lost_cnt_t      lost_cnt;
    spi_rx_record_t rec;
    logic           rec_write;
    logic           fifo_full;

    spi_rx_regs spi_rx_regs_inst (
        .SCLK         (SCLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out),
        .lost_cnt     (lost_cnt),
        .conf_en      (conf_en),
        .clear        (clear)
    );

    spi_rx_deser spi_rx_deser_inst (
        .SCLK      (SCLK),
        .clear     (clear),
        .conf_en   (conf_en),
        .sdi       (sdi),
        .sen       (sen),
        .fifo_full (fifo_full),
        .rec       (rec),
        .rec_write (rec_write),
        .lost_cnt  (lost_cnt)
    );

    spi_rx_fifo spi_rx_fifo_inst (
        .SCLK  (SCLK),
        .clear (clear),
        .write (rec_write),
        .wdata (rec),
        .read  (fifo_read),
        .rdata (fifo_data),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

endmodule

// ==== sources.f ====
design/spi_rx_bus_pkg.sv
design/spi_rx_data_pkg.sv
design/spi_rx_regs.sv
design/spi_rx_deser.sv
design/spi_rx_fifo.sv
design/spi_rx_top.sv
verif/spi_rx_tb.sv

// ==== verif/spi_rx_tb.sv ====
//########################################
// Testbench for the serial receiver
// Stimulus table, serial driver, bus tasks
// Record queue model and compare tasks
// Cycle-count timeout
//########################################

`timescale 1ns/1ps

module spi_rx_tb
    import spi_rx_bus_pkg::*;
    import spi_rx_data_pkg::*;
();

    typedef struct packed {
        logic        en;
        logic [15:0] bits;
        logic        rd;
        lost_cnt_t   lost;
    } row_t;

    localparam int NUM_ROWS  = 8;
    localparam int RESET_ROW = 6;

    // Enable, frame length, host reads, lost count after the row
    row_t rows [NUM_ROWS] = '{
        '{1'b0, 16'd40,   1'b1, 8'd0},
        '{1'b1, 16'd16,   1'b1, 8'd0},
        '{1'b1, 16'd37,   1'b1, 8'd0},
        '{1'b1, 16'd5,    1'b1, 8'd0},
        '{1'b1, 16'd320,  1'b0, 8'd4},
        '{1'b1, 16'd4800, 1'b0, 8'd255},
        '{1'b1, 16'd24,   1'b1, 8'd0},
        '{1'b1, 16'd33,   1'b1, 8'd0}
    };

    logic           SCLK;
    logic           RST;
    logic           sdi;
    logic           sen;
    logic           fifo_read;
    logic           fifo_empty;
    spi_rx_record_t fifo_data;
    bus_addr_t      bus_add;
    bus_data_t      bus_data_in;
    logic           bus_wr;
    bus_data_t      bus_data_out;

    // Reference model state
    spi_rx_record_t        exp_q [$];
    logic [FRAME_BITS-1:0] model_frame;
    logic                  model_en;

    integer    seed = 32'h5226;
    int        cycles = 0;
    int        cycle_limit = 2000;
    bus_data_t rd_data;

    spi_rx_top spi_rx_top_inst (
        .SCLK         (SCLK),
        .RST          (RST),
        .sdi          (sdi),
        .sen          (sen),
        .fifo_read    (fifo_read),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_data),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out)
    );

    always #5 SCLK = ~SCLK;

    always @(posedge SCLK) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic check_record(spi_rx_record_t expected, spi_rx_record_t actual);
        if (actual !== expected) begin
            $display("mismatch fifo_data expected %h actual %h", expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "record check failed");
        end
    endtask

    task automatic check_reg(string name, bus_data_t expected, bus_data_t actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "register check failed");
        end
    endtask

    task automatic check_flag(logic expected, logic actual);
        if (actual !== expected) begin
            $display("mismatch fifo_empty expected %h actual %h", expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "flag check failed");
        end
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge SCLK);
            #1;
            fifo_read = 1'b0;
            bus_wr    = 1'b0;
        end
    endtask

    task automatic write_reg(bus_addr_t addr, bus_data_t data);
        @(posedge SCLK);
        #1;
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(posedge SCLK);
        #1;
        bus_wr = 1'b0;
    endtask

    // Read data is registered, so sample one edge after the address
    task automatic read_reg(bus_addr_t addr, output bus_data_t data);
        @(posedge SCLK);
        #1;
        bus_add = addr;
        @(posedge SCLK);
        #1;
        data = bus_data_out;
    endtask

    task automatic expect_word(logic [WORD_BITS-1:0] data);
        spi_rx_record_t rec;
        rec.source_id = 4'b0001;
        rec.frame     = model_frame;
        rec.data      = data;
        // Words that find the FIFO full are dropped
        if (model_en && (exp_q.size() < FIFO_DEPTH)) begin
            exp_q.push_back(rec);
        end
    endtask

    task automatic pop_and_check();
        spi_rx_record_t expected;
        if (exp_q.size() == 0) begin
            $display("the FIFO holds a record that no frame should have produced");
            $display("TEST RESULT: FAIL");
            $fatal(1, "unexpected record");
        end
        expected = exp_q.pop_front();
        check_record(expected, fifo_data);
        fifo_read = 1'b1;
    endtask

    task automatic service_read(logic rd);
        fifo_read = 1'b0;
        if (rd && !fifo_empty) begin
            pop_and_check();
        end
    endtask

    task automatic run_frame(int bits, logic rd);
        logic [WORD_BITS-1:0] acc;
        int                   k;
        integer               r;
        acc = '0;
        k   = 0;
        for (int i = 0; i < bits; i++) begin
            @(posedge SCLK);
            #1;
            service_read(rd);
            r   = $random(seed);
            sdi = r[0];
            sen = 1'b1;
            acc = {acc[WORD_BITS-2:0], r[0]};
            k   = k + 1;
            if (k == WORD_BITS) begin
                expect_word(acc);
                acc = '0;
                k   = 0;
            end
        end
        @(posedge SCLK);
        #1;
        service_read(rd);
        sen = 1'b0;
        sdi = 1'b0;
        // Tail is right-aligned, empty tails give no record
        if (k != 0) begin
            expect_word(acc);
        end
        if (model_en) begin
            model_frame = model_frame + 1'b1;
        end
    endtask

    task automatic drain_fifo();
        while (exp_q.size() > 0) begin
            @(posedge SCLK);
            #1;
            fifo_read = 1'b0;
            if (!fifo_empty) begin
                pop_and_check();
            end
        end
        idle(1);
        check_flag(1'b1, fifo_empty);
    endtask

    task automatic apply_row(row_t row);
        bus_data_t data;
        write_reg(ADDR_CONF, {7'b0, row.en});
        model_en = row.en;
        run_frame(int'(row.bits), row.rd);
        idle(3);
        drain_fifo();
        read_reg(ADDR_LOST, data);
        check_reg("lost count", row.lost, data);
    endtask

    // Leaves records in the FIFO, then clears everything by a bus write
    task automatic soft_reset_check();
        bus_data_t data;
        run_frame(48, 1'b0);
        idle(3);
        check_flag(1'b0, fifo_empty);
        write_reg(ADDR_RESET, 8'h00);
        exp_q.delete();
        model_frame = '0;
        model_en    = 1'b0;
        check_flag(1'b1, fifo_empty);
        read_reg(ADDR_CONF, data);
        check_reg("enable", 8'h00, data);
        read_reg(ADDR_LOST, data);
        check_reg("lost count", 8'h00, data);
    endtask

    initial begin
        SCLK        = 1'b0;
        RST         = 1'b1;
        sdi         = 1'b0;
        sen         = 1'b0;
        fifo_read   = 1'b0;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        model_frame = '0;
        model_en    = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += int'(rows[i].bits) + int'(rows[i].bits) / WORD_BITS + 1;
        end
        repeat (10) @(posedge SCLK);
        #1;
        RST = 1'b0;

        read_reg(ADDR_RESET, rd_data);
        check_reg("version", 8'h01, rd_data);
        read_reg(ADDR_CONF, rd_data);
        check_reg("enable", 8'h00, rd_data);
        read_reg(ADDR_LOST, rd_data);
        check_reg("lost count", 8'h00, rd_data);
        check_flag(1'b1, fifo_empty);
        write_reg(ADDR_CONF, 8'h01);
        read_reg(ADDR_CONF, rd_data);
        check_reg("enable", 8'h01, rd_data);

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i == RESET_ROW) begin
                soft_reset_check();
            end
            apply_row(rows[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
